/* firDecim_defines.svh */
`ifndef FIR_DECIM_DEFINES_SVH
`define FIR_DECIM_DEFINES_SVH

// Input bits per output sample
`define FIR_DSR 4

// Taps in each of the lookahead and lookback halves
`define FIR_TAPS_HALF 8
`define FIR_TAPS (2 * `FIR_TAPS_HALF)

// Input bits that address one lookup group
`define FIR_LUT_BITS 4

// Coefficient fraction bits, sign only besides
`define FIR_COEF_FRAC 14

// Accumulator width, headroom for a full window of coefficients
`define FIR_ACC_WIDTH 20

// Output code width
`define FIR_OUT_WIDTH 12

`endif

/* fxpPkg.sv */
`include "firDecim_defines.svh"

package fxpPkg;

    // Sign plus fraction bits
    typedef logic signed [`FIR_COEF_FRAC:0] coefT;

    // Same fraction as coefT, wider integer part
    typedef logic signed [`FIR_ACC_WIDTH-1:0] accT;

    // Offset binary output code
    typedef logic [`FIR_OUT_WIDTH-1:0] outT;

    // Packed input bits, bit 0 is the newest
    typedef logic [`FIR_DSR-1:0] wordT;

    // Shift that moves the coefficient fraction onto the output fraction
    localparam int outShift = `FIR_COEF_FRAC - (`FIR_OUT_WIDTH - 1);

    // Signed range of the output before offset conversion
    localparam accT satMax = accT'((1 <<< (`FIR_OUT_WIDTH - 1)) - 1);
    localparam accT satMin = accT'(-(1 <<< (`FIR_OUT_WIDTH - 1)));

endpackage

/* firCoefPkg.sv */
`include "firDecim_defines.svh"

package firCoefPkg;

    import fxpPkg::*;

    // Symmetric low-pass response, index 0 weights the newest bit
    // Sum is 0.75 so a full-scale DC input stays inside the output range
    localparam coefT firCoefs [`FIR_TAPS] = '{
        coefT'(96),
        coefT'(224),
        coefT'(448),
        coefT'(704),
        coefT'(960),
        coefT'(1152),
        coefT'(1216),
        coefT'(1344),
        coefT'(1344),
        coefT'(1216),
        coefT'(1152),
        coefT'(960),
        coefT'(704),
        coefT'(448),
        coefT'(224),
        coefT'(96)
    };

    // Distributed-arithmetic table entry for one group of input bits
    // A one adds its coefficient, a zero subtracts it
    function automatic accT lutEntry(input int base, input int sel);
        accT acc;
        acc = '0;
        for (int k = 0; k < `FIR_LUT_BITS; k++) begin
            if (sel[k]) begin
                acc = acc + accT'(firCoefs[base + k]);
            end else begin
                acc = acc - accT'(firCoefs[base + k]);
            end
        end
        return acc;
    endfunction

endpackage

/* samplePacker.sv */
`include "firDecim_defines.svh"

module samplePacker (
    input  logic         clk,
    input  logic         rstN,
    input  logic         sdIn,
    output fxpPkg::wordT word,
    output logic         wordStrobe
);
    localparam int phaseWidth = $clog2(`FIR_DSR);
    localparam logic [phaseWidth-1:0] lastPhase = phaseWidth'(`FIR_DSR - 1);
    localparam int keepBits = `FIR_DSR - 1;

    logic [phaseWidth-1:0] phase;
    logic [keepBits-1:0] shiftReg;

    // Bit position within the current group
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase <= '0;
            wordStrobe <= 1'b0;
        end else begin
            wordStrobe <= (phase == lastPhase);
            if (phase == lastPhase) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    // Newest bit enters at position 0
    always_ff @(posedge clk) begin
        shiftReg <= keepBits'({shiftReg, sdIn});
        if (phase == lastPhase) begin
            word <= {shiftReg, sdIn};
        end
    end

endmodule

/* historyBuffer.sv */
`include "firDecim_defines.svh"

module historyBuffer (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      wordStrobe,
    input  fxpPkg::wordT              word,
    output logic [`FIR_TAPS_HALF-1:0] aheadBits,
    output logic [`FIR_TAPS_HALF-1:0] backBits,
    output logic                      windowStrobe
);
    localparam int windowWords = `FIR_TAPS / `FIR_DSR;
    localparam int countWidth = $clog2(windowWords + 1);
    localparam logic [countWidth-1:0] fullCount = countWidth'(windowWords);

    logic [`FIR_TAPS-1:0] window;
    logic [countWidth-1:0] wordCount;
    logic fillsWindow;

    // True for the word that completes the window and every word after it
    assign fillsWindow = (wordCount >= fullCount - 1'b1);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            window <= '0;
            wordCount <= '0;
            windowStrobe <= 1'b0;
        end else begin
            windowStrobe <= wordStrobe && fillsWindow;
            if (wordStrobe) begin
                window <= {window[`FIR_TAPS-1-`FIR_DSR:0], word};
                if (wordCount != fullCount) begin
                    wordCount <= wordCount + 1'b1;
                end
            end
        end
    end

    // Bit index equals bit age, so it also selects the coefficient
    assign aheadBits = window[`FIR_TAPS_HALF-1:0];
    assign backBits = window[`FIR_TAPS-1:`FIR_TAPS_HALF];

endmodule

/* lutAdderTree.sv */
`include "firDecim_defines.svh"

module lutAdderTree #(
    parameter int coefBase = 0
) (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [`FIR_TAPS_HALF-1:0] bitsIn,
    output fxpPkg::accT               sum
);
    import fxpPkg::*;
    import firCoefPkg::*;

    localparam int groupCount = `FIR_TAPS_HALF / `FIR_LUT_BITS;
    localparam int lutDepth = 1 << `FIR_LUT_BITS;
    localparam int treeLevels = $clog2(groupCount);

    accT lutTable [groupCount][lutDepth];

    // Level 0 holds the registered LUT outputs, the last level the sum
    accT stage [treeLevels+1][groupCount];

    // One constant table per group of input bits
    for (genvar g = 0; g < groupCount; g++) begin : groupRom
        for (genvar e = 0; e < lutDepth; e++) begin : romEntry
            assign lutTable[g][e] = lutEntry(coefBase + g * `FIR_LUT_BITS, e);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int g = 0; g < groupCount; g++) begin
                stage[0][g] <= '0;
            end
        end else begin
            for (int g = 0; g < groupCount; g++) begin
                stage[0][g] <= lutTable[g][bitsIn[g*`FIR_LUT_BITS +: `FIR_LUT_BITS]];
            end
        end
    end

    // Pairwise reduction, an odd node is passed on unchanged
    for (genvar l = 1; l <= treeLevels; l++) begin : treeLevel
        localparam int nPrev = (groupCount + (1 << (l - 1)) - 1) >> (l - 1);
        localparam int nCur = (groupCount + (1 << l) - 1) >> l;

        always_ff @(posedge clk or negedge rstN) begin
            if (!rstN) begin
                for (int k = 0; k < nCur; k++) begin
                    stage[l][k] <= '0;
                end
            end else begin
                for (int k = 0; k < nCur; k++) begin
                    if (2 * k + 1 < nPrev) begin
                        stage[l][k] <= stage[l-1][2*k] + stage[l-1][2*k+1];
                    end else begin
                        stage[l][k] <= stage[l-1][2*k];
                    end
                end
            end
        end
    end

    assign sum = stage[treeLevels][0];

endmodule

/* decimFirCore.sv */
`include "firDecim_defines.svh"

module decimFirCore (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      windowStrobe,
    input  logic [`FIR_TAPS_HALF-1:0] aheadBits,
    input  logic [`FIR_TAPS_HALF-1:0] backBits,
    output fxpPkg::outT               out,
    output logic                      outValid
);
    import fxpPkg::*;

    // LUT register plus one cycle per adder level, then the final add
    localparam int treeLatency = 1 + $clog2(`FIR_TAPS_HALF / `FIR_LUT_BITS);
    localparam int alignDepth = treeLatency + 1;

    accT aheadSum;
    accT backSum;
    accT totalSum;
    accT scaled;
    logic signed [`FIR_OUT_WIDTH-1:0] clipped;
    outT code;
    logic [alignDepth-1:0] strobeDly;

    lutAdderTree #(
        .coefBase(0)
    ) aheadSum_i (
        .clk(clk),
        .rstN(rstN),
        .bitsIn(aheadBits),
        .sum(aheadSum)
    );

    lutAdderTree #(
        .coefBase(`FIR_TAPS_HALF)
    ) backSum_i (
        .clk(clk),
        .rstN(rstN),
        .bitsIn(backBits),
        .sum(backSum)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            totalSum <= '0;
            strobeDly <= '0;
        end else begin
            totalSum <= aheadSum + backSum;
            strobeDly <= {strobeDly[alignDepth-2:0], windowStrobe};
        end
    end

    // Arithmetic shift rounds toward minus infinity
    assign scaled = totalSum >>> outShift;

    always_comb begin
        if (scaled > satMax) begin
            clipped = satMax[`FIR_OUT_WIDTH-1:0];
        end else if (scaled < satMin) begin
            clipped = satMin[`FIR_OUT_WIDTH-1:0];
        end else begin
            clipped = scaled[`FIR_OUT_WIDTH-1:0];
        end
    end

    // Two's complement to offset binary
    assign code = {~clipped[`FIR_OUT_WIDTH-1], clipped[`FIR_OUT_WIDTH-2:0]};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            out <= '0;
            outValid <= 1'b0;
        end else begin
            outValid <= strobeDly[alignDepth-1];
            if (strobeDly[alignDepth-1]) begin
                out <= code;
            end
        end
    end

endmodule

/* sdDecimator.sv */
`include "firDecim_defines.svh"

module sdDecimator (
    input  logic        clk,
    input  logic        rstN,
    input  logic        sdIn,
    output fxpPkg::outT out,
    output logic        outValid
);
    import fxpPkg::*;

    wordT word;
    logic wordStrobe;
    logic [`FIR_TAPS_HALF-1:0] aheadBits;
    logic [`FIR_TAPS_HALF-1:0] backBits;
    logic windowStrobe;

    // Bitstream to words
    samplePacker packer_i (
        .clk(clk),
        .rstN(rstN),
        .sdIn(sdIn),
        .word(word),
        .wordStrobe(wordStrobe)
    );

    historyBuffer history_i (
        .clk(clk),
        .rstN(rstN),
        .wordStrobe(wordStrobe),
        .word(word),
        .aheadBits(aheadBits),
        .backBits(backBits),
        .windowStrobe(windowStrobe)
    );

    // Filter, scale and format
    decimFirCore core_i (
        .clk(clk),
        .rstN(rstN),
        .windowStrobe(windowStrobe),
        .aheadBits(aheadBits),
        .backBits(backBits),
        .out(out),
        .outValid(outValid)
    );

endmodule

/* sdDecimatorTb.sv */
`include "firDecim_defines.svh"

module sdDecimatorTb;
    import firCoefPkg::*;

    localparam int clkPeriod = 4;
    localparam int resetCycles = 5;
    // Two LUT stages, final add, output register
    localparam int coreLatency = 4;
    // Edges from sampling the newest window bit to the out update
    localparam int windowLag = 2 + coreLatency;
    localparam int firstValid = `FIR_TAPS - 1 + windowLag;
    localparam int flushCycles = windowLag + `FIR_DSR;
    localparam int scaleShift = `FIR_COEF_FRAC - (`FIR_OUT_WIDTH - 1);
    localparam int codeMax = (1 << (`FIR_OUT_WIDTH - 1)) - 1;
    localparam int codeMin = -(1 << (`FIR_OUT_WIDTH - 1));

    localparam int kindConst = 0;
    localparam int kindPattern = 1;
    localparam int kindRandom = 2;

    // Coefficient sum of 0.75 never reaches the clip range, so no saturation entry
    localparam int numEntries = 6;
    string entryName [numEntries] = '{
        "zeros", "ones step", "alternating", "random", "blocks", "zeros step"
    };
    localparam int entryKind [numEntries] = '{
        kindConst, kindConst, kindPattern, kindRandom, kindPattern, kindConst
    };
    localparam logic [15:0] entryPattern [numEntries] = '{
        16'h0000, 16'hFFFF, 16'hAAAA, 16'h0000, 16'hF0F0, 16'h0000
    };
    localparam int entryWords [numEntries] = '{6, 6, 8, 40, 8, 6};
    // Steady-state code or -1 where only the model applies
    localparam int entryExpect [numEntries] = '{512, 3584, 2048, -1, 2048, 512};

    logic clk;
    logic rstN;
    logic sdIn;
    logic [`FIR_OUT_WIDTH-1:0] out;
    logic outValid;

    logic bits [$];
    int tags [$];
    int cycle = 0;
    int errors = 0;
    int checks = 0;
    int pulses = 0;
    logic [`FIR_OUT_WIDTH-1:0] lastOut = '0;

    sdDecimator dut_i (
        .clk(clk),
        .rstN(rstN),
        .sdIn(sdIn),
        .out(out),
        .outValid(outValid)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    task automatic compareValue(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at time %0t: %s expected %0d, got %0d",
                     $time, what, expected, actual);
        end
    endtask

    function automatic string entryLabel(input int tag);
        if (tag < 0) begin
            return "flush";
        end
        return entryName[tag];
    endfunction

    // Each bit weighs its coefficient as +1 or -1
    function automatic int modelCode(input logic [`FIR_TAPS-1:0] win);
        int acc;
        int scaled;
        acc = 0;
        for (int i = 0; i < `FIR_TAPS; i++) begin
            if (win[i]) begin
                acc += int'(firCoefs[i]);
            end else begin
                acc -= int'(firCoefs[i]);
            end
        end
        scaled = acc >>> scaleShift;
        if (scaled > codeMax) begin
            scaled = codeMax;
        end else if (scaled < codeMin) begin
            scaled = codeMin;
        end
        return scaled - codeMin;
    endfunction

    task automatic checkOutputs();
        logic expValid;
        logic [`FIR_TAPS-1:0] win;
        int newest;
        bit sameEntry;
        expValid = (cycle >= firstValid) && ((cycle - firstValid) % `FIR_DSR == 0);
        if (outValid !== expValid) begin
            errors++;
            if (expValid) begin
                $display("ERROR at time %0t: outValid missing in cycle %0d", $time, cycle);
            end else begin
                $display("ERROR at time %0t: outValid pulsed early or twice in cycle %0d",
                         $time, cycle);
            end
        end
        if (outValid === 1'b1 && expValid) begin
            newest = cycle - windowLag;
            sameEntry = 1'b1;
            for (int i = 0; i < `FIR_TAPS; i++) begin
                win[i] = bits[newest - i];
                if (tags[newest - i] != tags[newest]) begin
                    sameEntry = 1'b0;
                end
            end
            compareValue(entryLabel(tags[newest]), modelCode(win), out);
            if (sameEntry && tags[newest] >= 0 && entryExpect[tags[newest]] >= 0) begin
                compareValue({entryLabel(tags[newest]), " steady"},
                             entryExpect[tags[newest]], out);
            end
            lastOut = out;
            pulses++;
        end else if (outValid === 1'b1) begin
            lastOut = out;
        end else begin
            compareValue((cycle < firstValid) ? "warm-up" : "hold", lastOut, out);
        end
    endtask

    // Bit n is sampled on edge n + 1 after reset release
    task automatic runCycle(input logic b, input int tag);
        sdIn = b;
        bits.push_back(b);
        tags.push_back(tag);
        @(posedge clk);
        cycle++;
        #1;
        checkOutputs();
    endtask

    initial begin
        logic b;
        void'($urandom(32'hf8deb246));
        rstN = 1'b0;
        sdIn = 1'b0;
        repeat (resetCycles) begin
            @(posedge clk);
            #1;
            compareValue("reset out", 0, out);
            compareValue("reset outValid", 0, outValid);
        end
        rstN = 1'b1;
        for (int e = 0; e < numEntries; e++) begin
            for (int k = 0; k < entryWords[e] * `FIR_DSR; k++) begin
                case (entryKind[e])
                    kindConst: b = entryPattern[e][0];
                    kindPattern: b = entryPattern[e][k % 16];
                    default: b = 1'($urandom() & 32'd1);
                endcase
                runCycle(b, e);
            end
        end
        repeat (flushCycles) begin
            runCycle(1'b0, -1);
        end
        $display("Summary: %0d checks, %0d output pulses, %0d errors", checks, pulses, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Run length plus reset, flush and a margin
    initial begin
        int totalWords;
        int limit;
        totalWords = 0;
        for (int e = 0; e < numEntries; e++) begin
            totalWords += entryWords[e];
        end
        limit = totalWords * `FIR_DSR * clkPeriod
              + (resetCycles + flushCycles + 20) * clkPeriod;
        #(limit);
        $display("TIMEOUT: the run did not finish within %0d time units", limit);
        $display("Something failed");
        $finish;
    end

endmodule

/* src.f */
+incdir+.
fxpPkg.sv
firCoefPkg.sv
samplePacker.sv
historyBuffer.sv
lutAdderTree.sv
decimFirCore.sv
sdDecimator.sv
sdDecimatorTb.sv
